/* fetch_unit.f */
+incdir+design
design/fetch_pkg.sv
design/if_stage.sv
design/imem_ctrl.sv
design/predecode.sv
design/fetch_unit.sv
tests/fetch_unit_chk.sv
tests/fetch_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch front end testbench with Verilator
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f fetch_unit.f --top-module fetch_unit_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vfetch_unit_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

exit 0

/* tests/fetch_unit_tb.sv */
/*
 * fetch front end testbench
 * loads a short program in reset, then walks a table of dispatch,
 * stall and redirect rows, checking fetch and predecode results
 */
`timescale 1ns/100ps
`include "fetch_config.svh"

module fetch_unit_tb;

  localparam int NUM_ROWS     = 12;
  localparam int NUM_WORDS    = 3;           // 64-bit program words holding six instructions
  localparam int RESET_CYCLES = 3;
  localparam int WAIT_LIMIT   = 20;          // cycles before a wait gives up

  typedef struct {
    logic           dispatch;                // dispatch_en for one cycle
    logic           take_branch;             // redirect pulse
    fetch_pkg::pc_t target;
    int             hold;                    // stall cycles for rows with no movement
  } row_t;

  logic             clock = 1'b0;
  logic             reset;
  logic             dispatch_en;
  logic             co_ret_take_branch;
  fetch_pkg::pc_t   co_ret_target_pc;
  logic             load_en;
  fetch_pkg::pc_t   load_addr;
  logic [63:0]      load_data;
  fetch_pkg::pc_t   proc2imem_addr;
  fetch_pkg::pc_t   if_npc;
  fetch_pkg::inst_t if_ir;
  logic             if_valid_inst;
  logic             pd_is_branch;
  logic             pd_uncond;
  fetch_pkg::pc_t   pd_target;
  logic [4:0]       pd_dest_reg;
  logic             pd_has_dest;

  row_t             rows [NUM_ROWS];
  logic [63:0]      prog_words [NUM_WORDS];  // what the memory should hold
  fetch_pkg::pc_t   model_pc;                // PC the testbench expects
  integer           seed;
  int               cycles;
  bit               moved;

  fetch_unit u_fetch_unit (
    .clock              (clock),
    .reset              (reset),
    .dispatch_en        (dispatch_en),
    .co_ret_take_branch (co_ret_take_branch),
    .co_ret_target_pc   (co_ret_target_pc),
    .load_en            (load_en),
    .load_addr          (load_addr),
    .load_data          (load_data),
    .proc2imem_addr     (proc2imem_addr),
    .if_npc             (if_npc),
    .if_ir              (if_ir),
    .if_valid_inst      (if_valid_inst),
    .pd_is_branch       (pd_is_branch),
    .pd_uncond          (pd_uncond),
    .pd_target          (pd_target),
    .pd_dest_reg        (pd_dest_reg),
    .pd_has_dest        (pd_has_dest)
  );

  bind if_stage fetch_unit_chk u_fetch_unit_chk (
    .clock              (clock),
    .reset              (reset),
    .dispatch_en        (dispatch_en),
    .co_ret_take_branch (co_ret_take_branch),
    .co_ret_target_pc   (co_ret_target_pc),
    .proc2imem_addr     (proc2imem_addr),
    .if_valid_inst      (if_valid_inst)
  );

  always #20 clock = ~clock;                 // 40 ns period

  //////////////////////////////////////////////////
  // program and expected values
  //////////////////////////////////////////////////

  function automatic logic [31:0] branch_word(logic [5:0] opcode, logic [4:0] ra,
                                              logic [20:0] disp);
    return {opcode, ra, disp};
  endfunction

  function automatic logic [31:0] operate_word(logic [5:0] opcode, logic [4:0] ra,
                                               logic [4:0] rb, logic lit,
                                               logic [6:0] func, logic [4:0] rc);
    return {opcode, ra, rb, 3'b000, lit, func, rc};
  endfunction

  // low half sits at the lower address
  task automatic build_program();
    prog_words[0] = {branch_word(6'h30, 5'd26, 21'd2),            // 0x04 br r26, +2
                     operate_word(6'h10, 5'd1, 5'd2, 1'b0, 7'h20, 5'd3)};
    prog_words[1] = {branch_word(6'h34, 5'd26, 21'h1ffffd),       // 0x0c bsr r26, -3
                     branch_word(6'h39, 5'd5, 21'h1ffffe)};       // 0x08 beq r5, -2
    prog_words[2] = {6'h29, 5'd9, 5'd30, 16'h0010,                // 0x14 ldq, other
                     operate_word(6'h11, 5'd4, 5'd8, 1'b1, 7'h00, 5'd7)};
  endtask

  function automatic fetch_pkg::inst_t inst_at(fetch_pkg::pc_t pc);
    logic [63:0] word;
    word = prog_words[pc[4:3]];
    return pc[2] ? word[63:32] : word[31:0];
  endfunction

  // predecode rules taken straight from the instruction formats
  task automatic predict_decode(input fetch_pkg::inst_t ir, input fetch_pkg::pc_t npc,
                                output logic is_br, output logic uncond,
                                output logic has_dest, output logic [4:0] dest,
                                output fetch_pkg::pc_t target);
    logic [5:0]         opcode;
    logic signed [63:0] offset;
    opcode   = ir[31:26];
    offset   = {{43{ir[20]}}, ir[20:0]};     // sign-extended word displacement
    offset   = offset <<< 2;
    target   = npc + fetch_pkg::pc_t'(offset);
    is_br    = (opcode[5:4] == 2'b11);       // 0x30 .. 0x3f
    uncond   = (opcode == 6'h30) || (opcode == 6'h34);
    has_dest = 1'b1;
    dest     = ir[25:21];
    if (is_br) begin
      has_dest = uncond;                     // conditional branches write nothing
    end else if (opcode[5:2] == 4'b0100) begin
      dest = ir[4:0];                        // operate group writes rc
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////

  task automatic set_row(input int idx, input logic dispatch, input logic take,
                         input fetch_pkg::pc_t target, input int hold);
    rows[idx].dispatch    = dispatch;
    rows[idx].take_branch = take;
    rows[idx].target      = target;
    rows[idx].hold        = hold;
  endtask

  task automatic build_table();
    set_row(0,  1'b1, 1'b0, 64'h00, 0);      // 0x00 -> 0x04
    set_row(1,  1'b0, 1'b0, 64'h00, 1 + int'($unsigned($random(seed)) % 32'd8));
    set_row(2,  1'b1, 1'b0, 64'h00, 0);      // -> 0x08
    set_row(3,  1'b1, 1'b0, 64'h00, 0);      // -> 0x0c
    set_row(4,  1'b1, 1'b0, 64'h00, 0);      // -> 0x10
    set_row(5,  1'b1, 1'b0, 64'h00, 0);      // -> 0x14
    set_row(6,  1'b0, 1'b1, 64'h08, 0);      // redirect while stalled
    set_row(7,  1'b0, 1'b0, 64'h00, 1 + int'($unsigned($random(seed)) % 32'd8));
    set_row(8,  1'b1, 1'b1, 64'h10, 0);      // branch wins over the PC+4 step
    set_row(9,  1'b0, 1'b1, 64'h04, 0);
    set_row(10, 1'b1, 1'b0, 64'h00, 0);      // -> 0x08
    set_row(11, 1'b0, 1'b1, 64'h00, 0);      // back to the reset PC
  endtask

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_pc(input string name, input fetch_pkg::pc_t got,
                          input fetch_pkg::pc_t exp);
    if (got !== exp) begin
      fail_now($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_inst(input string name, input fetch_pkg::inst_t got,
                            input fetch_pkg::inst_t exp);
    if (got !== exp) begin
      fail_now($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_reg(input string name, input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      fail_now($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////
  // row handling
  //////////////////////////////////////////////////

  // polls on falling edges and gives up after WAIT_LIMIT cycles
  task automatic wait_valid(output int count);
    count = 0;
    while (if_valid_inst !== 1'b1) begin
      if (count >= WAIT_LIMIT) begin
        fail_now("timed out waiting for if_valid_inst to go high");
      end else begin
        @(negedge clock);
        count++;
      end
    end
  endtask

  task automatic apply_row(input row_t row, output bit pc_moved);
    pc_moved = row.dispatch || row.take_branch;
    if (pc_moved) begin
      dispatch_en        = row.dispatch;     // held one cycle while the instruction is valid
      co_ret_take_branch = row.take_branch;
      co_ret_target_pc   = row.target;
      @(negedge clock);
      dispatch_en        = 1'b0;
      co_ret_take_branch = 1'b0;
      co_ret_target_pc   = '0;
      model_pc = row.take_branch ? row.target : model_pc + 64'd4;
    end else begin
      // model PC stays put, so every stalled cycle shows the same fetch
      for (int c = 0; c < row.hold; c++) begin
        @(negedge clock);
        check_flag("if_valid_inst", if_valid_inst, 1'b1);
        check_fetch();
      end
    end
  endtask

  task automatic check_fetch();
    fetch_pkg::inst_t exp_ir;
    fetch_pkg::pc_t   exp_npc;
    fetch_pkg::pc_t   exp_target;
    logic             exp_br;
    logic             exp_uncond;
    logic             exp_has;
    logic [4:0]       exp_dest;
    exp_ir  = inst_at(model_pc);
    exp_npc = model_pc + 64'd4;
    predict_decode(exp_ir, exp_npc, exp_br, exp_uncond, exp_has, exp_dest, exp_target);
    check_pc("proc2imem_addr", proc2imem_addr, model_pc);
    check_pc("if_npc", if_npc, exp_npc);
    check_inst("if_ir", if_ir, exp_ir);
    check_flag("pd_is_branch", pd_is_branch, exp_br);
    check_flag("pd_uncond", pd_uncond, exp_uncond);
    check_flag("pd_has_dest", pd_has_dest, exp_has);
    if (exp_br) begin
      if (exp_ir[20]) begin
        check_flag("pd_target below pc", pd_target < model_pc, 1'b1);
      end
      check_pc("pd_target", pd_target, exp_target);
    end
    if (exp_has) begin
      check_reg("pd_dest_reg", pd_dest_reg, exp_dest);
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    seed               = 32'h107c_b4ee;
    reset              = 1'b1;
    dispatch_en        = 1'b0;
    co_ret_take_branch = 1'b0;
    co_ret_target_pc   = '0;
    load_en            = 1'b0;
    load_addr          = '0;
    load_data          = '0;
    build_program();
    build_table();

    // program goes in one word per cycle while reset is high
    for (int c = 0; c < RESET_CYCLES; c++) begin
      load_en   = (c < NUM_WORDS);
      load_addr = fetch_pkg::pc_t'(c) << 3;
      load_data = (c < NUM_WORDS) ? prog_words[c] : 64'h0;
      @(negedge clock);
    end
    load_en  = 1'b0;
    reset    = 1'b0;
    model_pc = `FETCH_RESET_PC;

    @(negedge clock);                        // first cycle out of reset
    check_pc("proc2imem_addr", proc2imem_addr, `FETCH_RESET_PC);
    check_flag("if_valid_inst", if_valid_inst, 1'b0);
    wait_valid(cycles);
    check_fetch();

    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(rows[r], moved);
      wait_valid(cycles);
      if (moved) begin
        check_count("fetch latency", cycles, `FETCH_IMEM_LATENCY);
      end
      check_fetch();
    end

    $display("Everything OK");
    $finish;
  end

endmodule

/* tests/fetch_unit_chk.sv */
/*
 * fetch stage checker
 * bound into if_stage, watches PC hold, redirect and valid out of reset
 */
`timescale 1ns/100ps

module fetch_unit_chk (
  input logic           clock,
  input logic           reset,
  input logic           dispatch_en,
  input logic           co_ret_take_branch,
  input fetch_pkg::pc_t co_ret_target_pc,
  input fetch_pkg::pc_t proc2imem_addr,
  input logic           if_valid_inst
);

  //////////////////////////////////////////////////
  // PC behavior
  //////////////////////////////////////////////////

  // no dispatch and no redirect, PC must not move
  pc_hold: assert property (
    @(posedge clock) disable iff (reset)
      (!dispatch_en && !co_ret_take_branch) |=> $stable(proc2imem_addr)
  ) else $error("PC changed while dispatch was low and no branch was taken");

  // redirect lands on the target one cycle after the pulse, stall or not
  pc_redirect: assert property (
    @(posedge clock) disable iff (reset)
      co_ret_take_branch |=> (proc2imem_addr == $past(co_ret_target_pc))
  ) else $error("PC did not take the branch target after a taken-branch pulse");

  //////////////////////////////////////////////////
  // valid out of reset
  //////////////////////////////////////////////////

  // memory count restarts in reset, nothing can be valid yet
  valid_after_reset: assert property (
    @(posedge clock) $fell(reset) |-> !if_valid_inst
  ) else $error("if_valid_inst was high in the first cycle after reset");

endmodule

/* design/fetch_unit.sv */
/*
 * fetch front end top
 * fetch stage, instruction memory and predecode wired together
 */
`timescale 1ns/100ps

module fetch_unit (
  input  logic             clock,
  input  logic             reset,
  input  logic             dispatch_en,
  input  logic             co_ret_take_branch,
  input  fetch_pkg::pc_t   co_ret_target_pc,
  input  logic             load_en,           // program load, used while in reset
  input  fetch_pkg::pc_t   load_addr,
  input  logic [63:0]      load_data,
  output fetch_pkg::pc_t   proc2imem_addr,
  output fetch_pkg::pc_t   if_npc,
  output fetch_pkg::inst_t if_ir,
  output logic             if_valid_inst,
  output logic             pd_is_branch,
  output logic             pd_uncond,
  output fetch_pkg::pc_t   pd_target,
  output logic [4:0]       pd_dest_reg,
  output logic             pd_has_dest
);

  logic [63:0] imem_data;                     // memory word back to fetch
  logic        imem_valid;

  if_stage u_if_stage (
    .clock              (clock),
    .reset              (reset),
    .dispatch_en        (dispatch_en),
    .co_ret_take_branch (co_ret_take_branch),
    .co_ret_target_pc   (co_ret_target_pc),
    .imem_data          (imem_data),
    .imem_valid         (imem_valid),
    .proc2imem_addr     (proc2imem_addr),
    .if_npc             (if_npc),
    .if_ir              (if_ir),
    .if_valid_inst      (if_valid_inst)
  );

  imem_ctrl u_imem_ctrl (
    .clock          (clock),
    .reset          (reset),
    .proc2imem_addr (proc2imem_addr),
    .load_en        (load_en),
    .load_addr      (load_addr),
    .load_data      (load_data),
    .imem_data      (imem_data),
    .imem_valid     (imem_valid)
  );

  // purely combinational, looks at whatever fetch is presenting
  predecode u_predecode (
    .if_ir        (if_ir),
    .if_npc       (if_npc),
    .pd_is_branch (pd_is_branch),
    .pd_uncond    (pd_uncond),
    .pd_target    (pd_target),
    .pd_dest_reg  (pd_dest_reg),
    .pd_has_dest  (pd_has_dest)
  );

endmodule

/* design/predecode.sv */
/*
 * fetch predecode
 * reads the fetched word as branch and operate format, reports
 * branch class, branch target and destination register
 */
`timescale 1ns/100ps

module predecode (
  input  fetch_pkg::inst_t if_ir,
  input  fetch_pkg::pc_t   if_npc,            // PC+4 of this instruction
  output logic             pd_is_branch,
  output logic             pd_uncond,         // BR or BSR
  output fetch_pkg::pc_t   pd_target,
  output logic [4:0]       pd_dest_reg,
  output logic             pd_has_dest
);

  logic [5:0]     opcode;
  logic           is_operate;
  fetch_pkg::pc_t disp_bytes;                 // sign-extended displacement in bytes

  //////////////////////////////////////////////////
  // classify
  //////////////////////////////////////////////////

  // opcode sits in the same bits in both views
  assign opcode = if_ir.br.opcode;

  assign pd_is_branch = (opcode >= fetch_pkg::OP_BRANCH_LO) &&
                        (opcode <= fetch_pkg::OP_BRANCH_HI);

  assign is_operate = (opcode >= fetch_pkg::OP_OPERATE_LO) &&
                      (opcode <= fetch_pkg::OP_OPERATE_HI);

  assign pd_uncond = (opcode == fetch_pkg::OP_BR) || (opcode == fetch_pkg::OP_BSR);

  //////////////////////////////////////////////////
  // branch target
  //////////////////////////////////////////////////

  // word displacement, scaled by 4 and sign extended to 64 bits
  assign disp_bytes = {{41{if_ir.br.disp[20]}}, if_ir.br.disp, 2'b00};

  // relative to the next PC, computed for any word and only meaningful on branches
  assign pd_target = if_npc + disp_bytes;

  //////////////////////////////////////////////////
  // destination register
  //////////////////////////////////////////////////

  always_comb begin
    pd_dest_reg = if_ir.br.ra;               // default, memory and misc formats write ra
    pd_has_dest = 1'b1;
    if (pd_is_branch) begin
      if (pd_uncond) begin
        pd_dest_reg = if_ir.br.ra;           // return address lands in ra
      end else begin
        pd_dest_reg = 5'd0;                  // conditional branch only tests ra
        pd_has_dest = 1'b0;
      end
    end else if (is_operate) begin
      pd_dest_reg = if_ir.op.rc;             // operate writes rc
    end
  end

endmodule

/* design/imem_ctrl.sv */
/*
 * instruction memory model
 * banked array loaded by the testbench, fixed wait states after
 * every new address before the addressed word is marked valid
 */
`timescale 1ns/100ps
`include "fetch_config.svh"

module imem_ctrl (
  input  logic           clock,
  input  logic           reset,
  input  fetch_pkg::pc_t proc2imem_addr,      // byte address from fetch
  input  logic           load_en,             // program load strobe
  input  fetch_pkg::pc_t load_addr,           // byte address of the word to load
  input  logic [63:0]    load_data,
  output logic [63:0]    imem_data,
  output logic           imem_valid
);

  localparam int WORDS   = `FETCH_IMEM_WORDS;
  localparam int LATENCY = `FETCH_IMEM_LATENCY;
  localparam int IDX_W   = $clog2(WORDS);
  localparam int CNT_W   = $clog2(LATENCY + 1);

  logic [63:0]      mem [WORDS];             // 64-bit words
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;

  fetch_pkg::pc_t   last_addr;               // address seen last cycle
  logic             addr_changed;
  logic [CNT_W-1:0] wait_cnt;                // wait states served on this address

  //////////////////////////////////////////////////
  // array and load port
  //////////////////////////////////////////////////

  // word index sits just above the byte-in-word bits
  assign rd_idx = proc2imem_addr[IDX_W+2:3];
  assign wr_idx = load_addr[IDX_W+2:3];

  always_ff @(posedge clock) begin
    if (load_en) begin
      mem[wr_idx] <= load_data;              // testbench writes during reset only
    end
  end

  // read data registered, so it is settled by the time the count expires
  always_ff @(posedge clock) begin
    imem_data <= mem[rd_idx];
  end

  //////////////////////////////////////////////////
  // wait-state counter
  //////////////////////////////////////////////////

  assign addr_changed = (proc2imem_addr != last_addr);

  always_ff @(posedge clock) begin
    if (reset) begin
      last_addr <= `FETCH_RESET_PC;          // count restarts out of reset
      wait_cnt  <= '0;
    end else begin
      last_addr <= proc2imem_addr;
      if (addr_changed) begin
        wait_cnt <= CNT_W'(1);               // first wait state served this cycle
      end else if (wait_cnt != CNT_W'(LATENCY)) begin
        wait_cnt <= wait_cnt + CNT_W'(1);
      end
    end
  end

  // valid drops in the very cycle a new address shows up
  // and rises LATENCY cycles later, holding while the address stays put
  assign imem_valid = !addr_changed && (wait_cnt == CNT_W'(LATENCY));

endmodule

/* design/if_stage.sv */
/*
 * instruction fetch stage
 * holds the PC, picks the next PC and hands the fetched half-word
 * plus PC+4 downstream
 */
`timescale 1ns/100ps
`include "fetch_config.svh"

module if_stage (
  input  logic            clock,
  input  logic            reset,
  input  logic            dispatch_en,         // downstream can take an instruction
  input  logic            co_ret_take_branch,  // one-cycle redirect from commit
  input  fetch_pkg::pc_t  co_ret_target_pc,    // redirect target, valid with the pulse
  input  logic [63:0]     imem_data,
  input  logic            imem_valid,
  output fetch_pkg::pc_t  proc2imem_addr,
  output fetch_pkg::pc_t  if_npc,
  output fetch_pkg::inst_t if_ir,
  output logic            if_valid_inst
);

  fetch_pkg::pc_t pc_reg;                      // address being fetched
  fetch_pkg::pc_t pc_plus_4;
  fetch_pkg::pc_t next_pc;
  logic           pc_enable;

  //////////////////////////////////////////////////
  // next PC
  //////////////////////////////////////////////////

  // a taken branch wins over a stall, otherwise the redirect is lost
  assign pc_enable = (dispatch_en & imem_valid) | co_ret_take_branch;

  assign pc_plus_4 = pc_reg + 64'd4;
  assign next_pc   = co_ret_take_branch ? co_ret_target_pc : pc_plus_4;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_reg <= `FETCH_RESET_PC;
    end else if (pc_enable) begin
      pc_reg <= next_pc;
    end
  end

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////

  assign proc2imem_addr = pc_reg;

  // memory word is 64 bits, bit 2 of the PC picks the half
  assign if_ir = fetch_pkg::inst_t'(pc_reg[2] ? imem_data[63:32] : imem_data[31:0]);

  assign if_npc        = pc_plus_4;            // travels with the instruction
  assign if_valid_inst = imem_valid;           // no request queue, memory valid is enough

endmodule

/* design/fetch_pkg.sv */
/*
 * fetch front end types
 * instruction format views, the instruction union and opcode values
 */
package fetch_pkg;

  typedef logic [63:0] pc_t;                 // program counter / byte address

  //////////////////////////////////////////////////
  // instruction formats, msb first
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [5:0]  opcode;                     // [31:26]
    logic [4:0]  ra;                         // [25:21] link or test register
    logic [20:0] disp;                       // [20:0] signed word displacement
  } branch_fmt_t;

  typedef struct packed {
    logic [5:0] opcode;                      // [31:26]
    logic [4:0] ra;                          // [25:21] first source
    logic [4:0] rb;                          // [20:16] second source
    logic [2:0] sbz;                         // [15:13] should be zero
    logic       lit_flag;                    // [12] rb field holds a literal
    logic [6:0] func;                        // [11:5] function code
    logic [4:0] rc;                          // [4:0] destination
  } operate_fmt_t;

  // same 32-bit word seen both ways, predecode picks the view
  typedef union packed {
    branch_fmt_t  br;
    operate_fmt_t op;
  } inst_t;

  //////////////////////////////////////////////////
  // opcodes
  //////////////////////////////////////////////////

  localparam logic [5:0] OP_BR  = 6'h30;     // unconditional branch
  localparam logic [5:0] OP_BSR = 6'h34;     // branch to subroutine

  localparam logic [5:0] OP_BRANCH_LO  = 6'h30;   // whole branch block
  localparam logic [5:0] OP_BRANCH_HI  = 6'h3f;
  localparam logic [5:0] OP_OPERATE_LO = 6'h10;   // integer operate group
  localparam logic [5:0] OP_OPERATE_HI = 6'h13;

endpackage

/* design/fetch_config.svh */
/*
 * fetch front end build parameters
 * memory size, wait states and the PC taken out of reset
 */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// number of 64-bit words in the instruction memory
// index comes from address bits above bit 2
`define FETCH_IMEM_WORDS 64

// wait states after a new address before imem_valid rises
`define FETCH_IMEM_LATENCY 2

// PC loaded on reset
`define FETCH_RESET_PC 64'h0

`endif
